/* source/audio_pkg.sv */
// audio mixer package with channel defaults, field widths and sample, word and level types

package audio_pkg;

    // channel count default, the top level may override it
    localparam int AUDIO_NCHAN = 4;
    // channel index width for the default count, modules rederive it from NCHAN
    localparam int CHAN_W      = $clog2(AUDIO_NCHAN);

    localparam int ADDR_W      = 16;        // memory word address
    localparam int PERIOD_W    = 15;        // counters carry one extra underflow bit
    localparam int LEN_W       = 15;        // loop length in words, minus one
    localparam int VOL_W       = 7;         // unsigned volume
    localparam int DAC_W       = 8;         // pdm level

    typedef logic signed [7:0]       sample_t;  // one signed 8-bit sample
    typedef logic [15:0]             word_t;    // high byte plays first
    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DAC_W-1:0]        level_t;   // unsigned, 8'h80 is silence

endpackage

/* source/fetch_if.sv */
// buffer fill link between the voice bank and the sample fetcher
`timescale 1ns/1ps

interface fetch_if #(
    parameter int NCHAN  = audio_pkg::AUDIO_NCHAN,
    parameter int ADDR_W = audio_pkg::ADDR_W
);
    import audio_pkg::*;

    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    logic [NCHAN-1:0]             need_fill;    // channel buffer empty
    logic [NCHAN-1:0][ADDR_W-1:0] addr;         // next word address per channel
    logic                         fill_valid;   // one-cycle store strobe
    logic [CHAN_W-1:0]            fill_chan;
    word_t                        fill_word;

    modport bank (
        output need_fill,
        output addr,
        input  fill_valid,
        input  fill_chan,
        input  fill_word
    );

    modport fetcher (
        input  need_fill,
        input  addr,
        output fill_valid,
        output fill_chan,
        output fill_word
    );

endinterface

/* source/sample_fetch.sv */
// round-robin fetcher, one memory word per empty channel buffer over a req/ack port
`timescale 1ns/1ps

module sample_fetch #(
    parameter int NCHAN  = audio_pkg::AUDIO_NCHAN,
    parameter int ADDR_W = audio_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              enable_i,
    fetch_if.fetcher          fill,
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic              mem_ack_i,
    input  audio_pkg::word_t  mem_word_i
);

    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    typedef enum logic [1:0] {
        PH_DMA,                             // present address, request if empty
        PH_READ,                            // wait for ack
        PH_NEXT                             // step to next channel
    } phase_t;

    phase_t            phase;
    logic [CHAN_W-1:0] chan;                // channel being visited
    logic              fill_ok;             // fetched word still wanted

    // a restart or disable during the read moves the channel on, so its word is dropped
    assign fill_ok = fill.need_fill[chan] && (fill.addr[chan] == mem_addr_o);

    assign fill.fill_valid = (phase == PH_READ) && mem_ack_i && fill_ok;
    assign fill.fill_chan  = chan;
    assign fill.fill_word  = mem_word_i;    // sampled by the bank in the ack cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase     <= PH_DMA;
            chan      <= '0;
            mem_req_o <= 1'b0;
        end else begin
            case (phase)
                PH_DMA: begin
                    mem_addr_o <= fill.addr[chan];              // latched for the whole read
                    if (enable_i && fill.need_fill[chan]) begin
                        mem_req_o <= 1'b1;
                        phase     <= PH_READ;
                    end else begin
                        phase     <= PH_NEXT;                   // idle channel, 2 cycles
                    end
                end
                PH_READ: begin
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;                      // falls right after ack
                        phase     <= PH_NEXT;
                    end
                end
                PH_NEXT: begin
                    if (chan == CHAN_W'(NCHAN - 1)) begin
                        chan <= '0;                             // wrap, also for odd counts
                    end else begin
                        chan <= chan + 1'b1;
                    end
                    phase <= PH_DMA;
                end
                default: begin
                    phase <= PH_DMA;
                end
            endcase
        end
    end

endmodule

/* source/voice_bank.sv */
// per-channel voices with period and length counters, word buffers and current samples
`timescale 1ns/1ps

module voice_bank #(
    parameter int NCHAN  = audio_pkg::AUDIO_NCHAN,
    parameter int ADDR_W = audio_pkg::ADDR_W
) (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    enable_i,
    input  logic [NCHAN-1:0][audio_pkg::PERIOD_W-1:0] period_i,
    input  logic [NCHAN-1:0][ADDR_W-1:0]            start_i,
    input  logic [NCHAN-1:0][audio_pkg::LEN_W-1:0]  len_i,
    input  logic [NCHAN-1:0]                        restart_i,
    output logic [NCHAN-1:0]                        reload_o,
    fetch_if.bank                                   fill,
    output logic [NCHAN-1:0][7:0]                   sample_vec_o
);
    import audio_pkg::*;

    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    logic [NCHAN-1:0][PERIOD_W:0] per_cnt;  // msb set means period expired
    logic [NCHAN-1:0][LEN_W:0]    len_cnt;  // words left after this one, msb forces reload
    logic [NCHAN-1:0][ADDR_W-1:0] addr_q;   // address of the word to fetch next
    word_t                        word_q [NCHAN];
    logic [NCHAN-1:0]             word_ok;  // buffer holds a fresh word
    logic [NCHAN-1:0]             second;   // next sample is the low byte
    sample_t                      val_q [NCHAN];
    logic [NCHAN-1:0]             tick;     // sample event
    logic [NCHAN-1:0]             last_word;

    always_comb begin
        for (int i = 0; i < NCHAN; i++) begin
            tick[i]         = per_cnt[i][PERIOD_W];
            last_word[i]    = len_cnt[i][LEN_W] || (len_cnt[i][LEN_W-1:0] == '0);
            sample_vec_o[i] = val_q[i];
        end
    end

    assign fill.need_fill = ~word_ok;
    assign fill.addr      = addr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            per_cnt  <= '1;                                 // expired
            len_cnt  <= '0;
            addr_q   <= '0;
            word_ok  <= '0;
            second   <= '0;
            reload_o <= '0;
            for (int i = 0; i < NCHAN; i++) begin
                val_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCHAN; i++) begin
                reload_o[i] <= 1'b0;                        // strobe
                per_cnt[i]  <= per_cnt[i] - 1'b1;

                if (fill.fill_valid && (fill.fill_chan == CHAN_W'(i))) begin
                    word_q[i]  <= fill.fill_word;
                    word_ok[i] <= 1'b1;
                end

                if (tick[i]) begin
                    // loading period-1 gives an event every period+1 cycles
                    per_cnt[i] <= {1'b0, period_i[i]} - 1'b1;
                    second[i]  <= ~second[i];
                    val_q[i]   <= second[i] ? word_q[i][7:0] : word_q[i][15:8];
                    if (second[i]) begin
                        word_ok[i] <= 1'b0;                 // word used up, stale if not refilled
                        if (last_word[i]) begin
                            addr_q[i]   <= start_i[i];      // loop back
                            len_cnt[i]  <= {1'b0, len_i[i]};
                            reload_o[i] <= 1'b1;
                        end else begin
                            addr_q[i]   <= addr_q[i] + 1'b1;
                            len_cnt[i]  <= len_cnt[i] - 1'b1;
                        end
                    end
                end

                if (restart_i[i]) begin
                    per_cnt[i][PERIOD_W] <= 1'b1;           // event next cycle
                    len_cnt[i][LEN_W]    <= 1'b1;           // and it reloads
                    second[i]            <= 1'b1;
                    word_ok[i]           <= 1'b0;
                    addr_q[i]            <= start_i[i];     // fetch from start right away
                end

                // idle voices sit at the top of the loop, first sample one period after enable
                if (!enable_i) begin
                    per_cnt[i]  <= {1'b0, period_i[i]} - 1'b1;
                    len_cnt[i]  <= {1'b0, len_i[i]};
                    addr_q[i]   <= start_i[i];
                    second[i]   <= 1'b0;                    // high byte first
                    word_ok[i]  <= 1'b0;
                    reload_o[i] <= 1'b0;
                end
            end
        end
    end

endmodule

/* source/voice_mixer.sv */
// channel scan with stereo volume multiply-accumulate, clamp and unsigned level output
`timescale 1ns/1ps

module voice_mixer #(
    parameter int NCHAN = audio_pkg::AUDIO_NCHAN
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic [NCHAN-1:0][7:0]                sample_vec_i,
    input  logic [NCHAN-1:0][audio_pkg::VOL_W-1:0] vol_l_i,
    input  logic [NCHAN-1:0][audio_pkg::VOL_W-1:0] vol_r_i,
    output audio_pkg::level_t                    level_l_o,
    output audio_pkg::level_t                    level_r_o
);
    import audio_pkg::*;

    localparam int IDX_W = $clog2(NCHAN + 1);
    // 16-bit product sum plus guard bits, so full scale on every channel clamps instead of wrapping
    localparam int ACC_W = 16 + $clog2(NCHAN);
    localparam int SUM_W = ACC_W - 6;

    logic [IDX_W-1:0]        mix_idx;       // 0..NCHAN, NCHAN is the terminal step
    logic                    mix_clr;       // clear accumulators
    sample_t                 smp_q;
    logic signed [VOL_W:0]   vol_l_q;       // zero-extended, always positive
    logic signed [VOL_W:0]   vol_r_q;
    logic signed [15:0]      prod_l;
    logic signed [15:0]      prod_r;
    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;
    logic signed [ACC_W-1:0] sum_l;         // includes the product of this cycle
    logic signed [ACC_W-1:0] sum_r;

    function automatic level_t to_level(input logic signed [SUM_W-1:0] s);
        level_t lv;
        if (s < -128) begin
            lv = '0;
        end else if (s > 127) begin
            lv = '1;
        end else begin
            lv = {~s[7], s[6:0]};           // offset binary
        end
        return lv;
    endfunction

    assign prod_l = smp_q * vol_l_q;
    assign prod_r = smp_q * vol_r_q;
    assign sum_l  = acc_l + prod_l;
    assign sum_r  = acc_r + prod_r;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_idx   <= '0;
            mix_clr   <= 1'b1;
            level_l_o <= '0;
            level_r_o <= '0;
        end else begin
            if (mix_idx == IDX_W'(NCHAN)) begin
                mix_idx   <= '0;
                mix_clr   <= 1'b1;
                // last channel product lands here, hence sum rather than acc
                level_l_o <= to_level(sum_l[ACC_W-1:6]);
                level_r_o <= to_level(sum_r[ACC_W-1:6]);
            end else begin
                mix_idx   <= mix_idx + 1'b1;
                mix_clr   <= 1'b0;
                smp_q     <= sample_vec_i[mix_idx];
                vol_l_q   <= {1'b0, vol_l_i[mix_idx]};
                vol_r_q   <= {1'b0, vol_r_i[mix_idx]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || mix_clr) begin
            acc_l <= '0;
            acc_r <= '0;
        end else begin
            acc_l <= sum_l;
            acc_r <= sum_r;
        end
    end

endmodule

/* source/pdm_dac.sv */
// first-order pulse density modulator, ones per 256 cycles track the level
`timescale 1ns/1ps

module pdm_dac #(
    parameter int WIDTH = audio_pkg::DAC_W
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] level_i,
    output logic             pulse_o
);

    logic [WIDTH-1:0] acc;                  // error accumulator
    logic [WIDTH:0]   sum;                  // msb is the carry out

    assign sum = {1'b0, acc} + {1'b0, level_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[WIDTH-1:0];
            pulse_o <= sum[WIDTH];          // registered carry drives the pin
        end
    end

endmodule

/* source/audio_mixer_top.sv */
// sample playback mixer top level with fetcher, voices, stereo mixer and pdm outputs
`timescale 1ns/1ps

module audio_mixer_top #(
    parameter int NCHAN  = audio_pkg::AUDIO_NCHAN,
    parameter int ADDR_W = audio_pkg::ADDR_W
) (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    audio_enable_i,
    input  logic [NCHAN-1:0][audio_pkg::VOL_W-1:0]  vol_l_i,
    input  logic [NCHAN-1:0][audio_pkg::VOL_W-1:0]  vol_r_i,
    input  logic [NCHAN-1:0][audio_pkg::PERIOD_W-1:0] period_i,
    input  logic [NCHAN-1:0][ADDR_W-1:0]            start_i,
    input  logic [NCHAN-1:0][audio_pkg::LEN_W-1:0]  len_i,
    input  logic [NCHAN-1:0]                        restart_i,
    output logic [NCHAN-1:0]                        reload_o,
    output logic                                    mem_req_o,
    output logic [ADDR_W-1:0]                       mem_addr_o,
    input  logic                                    mem_ack_i,
    input  audio_pkg::word_t                        mem_word_i,
    output logic                                    pdm_l_o,
    output logic                                    pdm_r_o
);
    import audio_pkg::*;

    logic [NCHAN-1:0][7:0] sample_vec;      // current sample per channel
    level_t                level_l;
    level_t                level_r;

    fetch_if #(.NCHAN(NCHAN), .ADDR_W(ADDR_W)) fill ();

    sample_fetch #(.NCHAN(NCHAN), .ADDR_W(ADDR_W)) u_fetch (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (audio_enable_i),
        .fill       (fill.fetcher),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_ack_i  (mem_ack_i),
        .mem_word_i (mem_word_i)
    );

    voice_bank #(.NCHAN(NCHAN), .ADDR_W(ADDR_W)) u_bank (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (audio_enable_i),
        .period_i     (period_i),
        .start_i      (start_i),
        .len_i        (len_i),
        .restart_i    (restart_i),
        .reload_o     (reload_o),
        .fill         (fill.bank),
        .sample_vec_o (sample_vec)
    );

    voice_mixer #(.NCHAN(NCHAN)) u_mix (
        .clk          (clk),
        .reset_i      (reset_i),
        .sample_vec_i (sample_vec),
        .vol_l_i      (vol_l_i),
        .vol_r_i      (vol_r_i),
        .level_l_o    (level_l),
        .level_r_o    (level_r)
    );

    pdm_dac #(.WIDTH(DAC_W)) dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .level_i (level_l),
        .pulse_o (pdm_l_o)
    );

    pdm_dac #(.WIDTH(DAC_W)) dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .level_i (level_r),
        .pulse_o (pdm_r_o)
    );

endmodule

/* test/audio_mixer_sva.sv */
// bound assertions on the memory req/ack protocol and the reload strobes
`timescale 1ns/1ps

module audio_mixer_sva #(
    parameter int NCHAN  = audio_pkg::AUDIO_NCHAN,
    parameter int ADDR_W = audio_pkg::ADDR_W
) (
    input logic              clk,
    input logic              reset_i,
    input logic              audio_enable_i,
    input logic [NCHAN-1:0]  reload_o,
    input logic              mem_req_o,
    input logic [ADDR_W-1:0] mem_addr_o,
    input logic              mem_ack_i
);

    int fail_count = 0;                         // failed assertions so far

    req_hold_a: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            fail_count++;
            $error("mem_req_o dropped or mem_addr_o moved before ack");
        end

    req_enable_a: assert property (@(posedge clk) disable iff (reset_i)
        $rose(mem_req_o) |-> $past(audio_enable_i))
        else begin
            fail_count++;
            $error("memory request raised while audio disabled");
        end

    reload_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
        (reload_o & $past(reload_o)) == '0)
        else begin
            fail_count++;
            $error("reload_o strobe longer than one cycle");
        end

    after_reset_a: assert property (@(posedge clk)
        $fell(reset_i) |-> !mem_req_o && (reload_o == '0))
        else begin
            fail_count++;
            $error("mem_req_o or reload_o high right after reset");
        end

endmodule

bind audio_mixer_top audio_mixer_sva #(.NCHAN(NCHAN), .ADDR_W(ADDR_W)) u_sva (
    .clk            (clk),
    .reset_i        (reset_i),
    .audio_enable_i (audio_enable_i),
    .reload_o       (reload_o),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_ack_i      (mem_ack_i)
);

/* test/audio_mixer_tb.sv */
// testbench for the audio mixer with memory model, reference functions and checking monitor
`timescale 1ns/1ps

module audio_mixer_tb;
    import audio_pkg::*;

    localparam int NCHAN   = 4;
    localparam int TIMEOUT = 3000;              // cycles allowed per wait

    logic                           clk;
    logic                           reset_i;
    logic                           audio_enable_i;
    logic [NCHAN-1:0][VOL_W-1:0]    vol_l_i;
    logic [NCHAN-1:0][VOL_W-1:0]    vol_r_i;
    logic [NCHAN-1:0][PERIOD_W-1:0] period_i;
    logic [NCHAN-1:0][ADDR_W-1:0]   start_i;
    logic [NCHAN-1:0][LEN_W-1:0]    len_i;
    logic [NCHAN-1:0]               restart_i;
    logic [NCHAN-1:0]               reload_o;
    logic                           mem_req_o;
    addr_t                          mem_addr_o;
    logic                           mem_ack_i = 1'b0;
    word_t                          mem_word_i = '0;
    logic                           pdm_l_o;
    logic                           pdm_r_o;

    int    n_errors = 0;
    int    n_checks = 0;
    int    n_req = 0;                           // request starts seen
    int    n_reload = 0;
    int    n_gap [NCHAN];                       // reload gaps compared per channel
    int    cycle = 0;
    logic  const_mode = 1'b0;                   // memory returns const_word
    word_t const_word = '0;
    logic  mem_busy = 1'b0;
    int    mem_lat = 0;
    logic  req_q = 1'b0;
    addr_t exp_addr [NCHAN];                    // next address per channel
    int    last_reload [NCHAN];                 // -1 when no reference pulse

    audio_mixer_top #(.NCHAN(NCHAN), .ADDR_W(ADDR_W)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every channel owns a 4k window, so address bits 13:12 name it
    function automatic int chan_of(input addr_t a);
        return int'(a[13:12]);
    endfunction

    function automatic word_t mem_pattern(input addr_t a);
        return {a[7:0] ^ 8'h3c, a[15:8] ^ a[7:0]};
    endfunction

    function automatic addr_t next_addr(input int c, input addr_t a);
        addr_t last;
        last = start_i[c] + ADDR_W'(len_i[c]);  // loop holds len+1 words
        if (a == last) begin
            return start_i[c];
        end
        return a + 1'b1;
    endfunction

    function automatic int reload_gap(input int c);
        return 2 * (int'(len_i[c]) + 1) * (int'(period_i[c]) + 1);
    endfunction

    function automatic int min_gaps();
        int m;
        m = n_gap[0];
        for (int c = 1; c < NCHAN; c++) begin
            if (n_gap[c] < m) begin
                m = n_gap[c];
            end
        end
        return m;
    endfunction

    function automatic int mix_level(input int s, input logic [NCHAN-1:0][VOL_W-1:0] v);
        int acc;
        acc = 0;
        for (int c = 0; c < NCHAN; c++) begin
            acc += s * int'(v[c]);
        end
        acc = acc >>> 6;
        if (acc > 127) begin
            acc = 127;
        end else if (acc < -128) begin
            acc = -128;
        end
        return acc + 128;                       // offset binary
    endfunction

    task automatic check(input string name, input int got, input int exp, input int tol);
        int diff;
        diff = (got > exp) ? got - exp : exp - got;
        n_checks++;
        if (diff > tol) begin
            n_errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h, tolerance %0d",
                     name, got, exp, tol);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timed out waiting for %s", what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_reload(input int c);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_abort($sformatf("reload_o on channel %0d", c));
        end while (!reload_o[c]);
    endtask

    task automatic wait_gaps(input int n);
        int t;
        t = 0;
        while (min_gaps() < n) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_abort("reload gaps on every channel");
        end
    endtask

    task automatic wait_fill(input int c);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_abort($sformatf("memory ack on channel %0d", c));
        end while (!(mem_ack_i && chan_of(mem_addr_o) == c));
    endtask

    task automatic check_duty(input string name, input int ones, input int lvl);
        if (lvl == 255) begin
            check({name, " zeros"}, 2048 - ones, 0, 8);
        end else if (lvl == 0) begin
            check({name, " ones"}, ones, 0, 0);
        end else begin
            check({name, " ones"}, ones, 8 * lvl, 8);
        end
    endtask

    task automatic run_mix(input word_t w, input logic [NCHAN-1:0][VOL_W-1:0] vl,
                           input logic [NCHAN-1:0][VOL_W-1:0] vr);
        int s;
        int ones_l;
        int ones_r;
        s = int'(sample_t'(w[15:8]));           // both bytes hold the same sample
        audio_enable_i <= 1'b0;
        wait_cycles(8);                         // pending read drains
        const_mode = 1'b1;
        const_word = w;
        vol_l_i <= vl;
        vol_r_i <= vr;
        audio_enable_i <= 1'b1;
        for (int c = 0; c < NCHAN; c++) begin
            wait_reload(c);                     // full loop of new samples
        end
        wait_cycles(2 * (NCHAN + 1) + 4);       // two mixer frames
        ones_l = 0;
        ones_r = 0;
        repeat (2048) begin
            @(posedge clk);
            ones_l += int'(pdm_l_o);
            ones_r += int'(pdm_r_o);
        end
        check_duty("pdm_l_o", ones_l, mix_level(s, vl));
        check_duty("pdm_r_o", ones_r, mix_level(s, vr));
    endtask

    // memory model acks 1 to 4 cycles after it sees the request
    always @(posedge clk) begin
        if (reset_i) begin
            mem_ack_i <= 1'b0;
            mem_busy = 1'b0;
        end else if (mem_ack_i) begin
            mem_ack_i <= 1'b0;                  // req falls on this edge
            mem_busy = 1'b0;
        end else if (mem_req_o) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_lat = int'($urandom_range(0, 3));
            end
            if (mem_lat == 0) begin
                mem_ack_i  <= 1'b1;
                mem_word_i <= const_mode ? const_word : mem_pattern(mem_addr_o);
            end else begin
                mem_lat = mem_lat - 1;
            end
        end
    end

    // compares request addresses and reload spacing with the reference
    always @(posedge clk) begin
        int ch;
        cycle = cycle + 1;
        if (!reset_i) begin
            if (mem_req_o && !req_q) begin      // new request
                ch = chan_of(mem_addr_o);
                n_req++;
                check($sformatf("mem_addr_o ch%0d", ch), int'(mem_addr_o),
                      int'(exp_addr[ch]), 0);
                exp_addr[ch] = next_addr(ch, exp_addr[ch]);
            end
            for (int c = 0; c < NCHAN; c++) begin
                if (reload_o[c]) n_reload++;
                if (!audio_enable_i || restart_i[c]) begin
                    exp_addr[c]    = start_i[c];        // voice back at loop top
                    last_reload[c] = -1;
                end else if (reload_o[c]) begin
                    if (last_reload[c] >= 0) begin
                        check($sformatf("reload_o[%0d] gap", c), cycle - last_reload[c],
                              reload_gap(c), 0);
                        n_gap[c]++;
                    end
                    last_reload[c] = cycle;
                end
            end
        end
        req_q = mem_req_o;
    end

    initial begin
        int req_mark;
        int reload_mark;
        void'($urandom(72101));
        reset_i = 1'b1;
        audio_enable_i = 1'b0;
        restart_i = '0;
        vol_l_i = '0;
        vol_r_i = '0;
        for (int c = 0; c < NCHAN; c++) begin
            period_i[c]    = PERIOD_W'(40 + 8 * c);            // at least 8 * NCHAN
            len_i[c]       = LEN_W'((c + 3) % 4 + 1);
            start_i[c]     = ADDR_W'(c * 'h1000 + 'h100 + c * 'h20);
            exp_addr[c]    = start_i[c];
            last_reload[c] = -1;
            n_gap[c]       = 0;
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        wait_cycles(4);

        audio_enable_i <= 1'b1;                 // address walk and reload spacing
        wait_gaps(3);

        audio_enable_i <= 1'b0;
        wait_cycles(8);
        req_mark    = n_req;
        reload_mark = n_reload;
        wait_cycles(500);
        check("mem_req_o starts while disabled", n_req - req_mark, 0, 0);
        check("reload_o pulses while disabled", n_reload - reload_mark, 0, 0);

        audio_enable_i <= 1'b1;
        wait_fill(2);                           // buffer full with no fetch pending
        wait_cycles(2);
        restart_i[2] <= 1'b1;
        @(posedge clk);
        restart_i[2] <= 1'b0;
        wait_reload(2);
        wait_fill(2);
        check("mem_addr_o after restart", int'(mem_addr_o), int'(start_i[2]), 0);

        run_mix(16'h1414, {7'd40, 7'd30, 7'd20, 7'd10}, {NCHAN{7'd5}});
        run_mix(16'he6e6, {7'd50, 7'd33, 7'd25, 7'd12}, {7'd9, 7'd0, 7'd60, 7'd60});
        run_mix(16'h7f7f, {NCHAN{7'd127}}, {NCHAN{7'd127}});   // clamps high
        run_mix(16'h8080, {NCHAN{7'd127}}, {NCHAN{7'd127}});   // clamps low

        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, DUT.u_sva.fail_count);
        if (n_errors == 0 && DUT.u_sva.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
source/audio_pkg.sv
source/fetch_if.sv
source/sample_fetch.sv
source/voice_bank.sv
source/voice_mixer.sv
source/pdm_dac.sv
source/audio_mixer_top.sv
test/audio_mixer_sva.sv
test/audio_mixer_tb.sv

/* run.sh */
#!/bin/sh
# build and run the audio mixer simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_mixer_tb -f compile.f -o sim_audio

./obj_dir/sim_audio | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
